// File: logic/icache_pkg.sv
// Instruction cache definitions
`default_nettype none

package icache_pkg;

  // ------------------------------
  // geometry
  // ------------------------------
  localparam int ADDR_W     = 32;  // byte address
  localparam int WORD_W     = 64;  // fetch word and bus beat
  localparam int LINE_WORDS = 4;   // words per line, beats per refill
  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 64;

  // address split is tag | index | offset
  localparam int OFFSET_W   = 5;
  localparam int INDEX_W    = 6;
  localparam int TAG_W      = 21;
  localparam int WSEL_W     = 2;   // addr[4:3]

  // ------------------------------
  // controller states
  // ------------------------------
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // ready for a request
    ST_LOOKUP = 2'd1,  // tag compare, hit return
    ST_RD_REQ = 2'd2,  // line read on the bus
    ST_REFILL = 2'd3   // taking the four beats
  } cache_state_e;

  // ------------------------------
  // structs
  // ------------------------------
  // request held across lookup and refill
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WSEL_W-1:0]  wsel;
  } req_t;

  // one refill beat written into a way
  typedef struct packed {
    logic               en;    // this way takes the beat
    logic [WSEL_W-1:0]  wsel;  // beat number
    logic [WORD_W-1:0]  data;
    logic               last;  // also write tag and valid
  } fill_t;

endpackage

`default_nettype wire

// File: logic/icache_ctrl.sv
// Instruction cache controller
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst,
  // fetch side
  input  wire logic                       i_valid,
  input  wire logic [TAG_W-1:0]           i_tag,
  input  wire logic [INDEX_W-1:0]         i_index,
  input  wire logic [OFFSET_W-1:0]        i_offset,
  output logic                            o_addr_ok,
  output logic                            o_data_ok,
  // way side
  input  wire logic                       i_hit,
  output logic                            o_refill,
  output req_t                            o_req,
  output logic [INDEX_W-1:0]              o_rd_index,
  output fill_t [NUM_WAYS-1:0]            o_fill,
  // bus side
  output logic                            o_rd_req,
  output logic [ADDR_W-1:0]               o_rd_addr,
  input  wire logic                       i_rd_rdy,
  input  wire logic                       i_ret_valid,
  input  wire logic                       i_ret_last,
  input  wire logic [WORD_W-1:0]          i_ret_data
);

  cache_state_e        state_q, state_d;
  req_t                req_q;
  logic [WSEL_W-1:0]   beat_q;     // beats taken so far
  logic                rr_q;       // way to replace next
  logic                accept;
  logic                beat;

  // ------------------------------
  // handshake
  // ------------------------------
  assign o_addr_ok = (state_q == ST_IDLE) || ((state_q == ST_LOOKUP) && i_hit);
  assign accept    = i_valid && o_addr_ok;
  assign beat      = (state_q == ST_REFILL) && i_ret_valid;

  // critical word goes out with its beat
  assign o_data_ok = ((state_q == ST_LOOKUP) && i_hit) || (beat && (beat_q == req_q.wsel));
  assign o_refill  = (state_q == ST_REFILL);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (accept) state_d = ST_LOOKUP;
      ST_LOOKUP: begin
        if (!i_hit) begin
          state_d = ST_RD_REQ;
        end else if (!i_valid) begin
          state_d = ST_IDLE;          // stays in lookup on back-to-back hit
        end
      end
      ST_RD_REQ: if (i_rd_rdy) state_d = ST_REFILL;
      ST_REFILL: if (i_ret_valid && i_ret_last) state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
      rr_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (o_rd_req && i_rd_rdy) begin
        beat_q <= '0;
      end else if (beat) begin
        beat_q <= beat_q + 1'b1;
      end
      if (beat && i_ret_last) begin
        rr_q <= ~rr_q;                // round robin per line fill
      end
    end
  end

  // request buffer
  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_q.tag   <= i_tag;
      req_q.index <= i_index;
      req_q.wsel  <= i_offset[OFFSET_W-1 -: WSEL_W];
    end
  end

  assign o_req      = req_q;
  assign o_rd_index = accept ? i_index : req_q.index;  // data array is one cycle ahead

  // ------------------------------
  // refill steering
  // ------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      o_fill[w].en   = beat && (int'(rr_q) == w);
      o_fill[w].wsel = beat_q;
      o_fill[w].data = i_ret_data;
      o_fill[w].last = i_ret_last;
    end
  end

  assign o_rd_req  = (state_q == ST_RD_REQ);
  assign o_rd_addr = {req_q.tag, req_q.index, {OFFSET_W{1'b0}}};  // line aligned

endmodule

`default_nettype wire

// File: logic/icache_way.sv
// Instruction cache way
`timescale 1ns/1ps
`default_nettype none

module icache_way import icache_pkg::*; (
  input  wire logic                 i_clk,
  input  wire logic                 i_rst,
  input  wire req_t                 i_req,
  input  wire logic [INDEX_W-1:0]   i_rd_index,
  input  wire fill_t                i_fill,
  output logic                      o_hit,
  output logic [WORD_W-1:0]         o_word
);

  // ------------------------------
  // tag and valid arrays
  // ------------------------------
  logic [TAG_W-1:0]    tag_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic                tag_wr;

  assign tag_wr = i_fill.en && i_fill.last;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
    end else if (tag_wr) begin
      valid_q[i_req.index] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (tag_wr) begin
      tag_mem[i_req.index] <= i_req.tag;
    end
  end

  // compare against the buffered request
  assign o_hit = valid_q[i_req.index] && (tag_mem[i_req.index] == i_req.tag);

  // ------------------------------
  // line data array
  // ------------------------------
  logic [LINE_WORDS-1:0][WORD_W-1:0] data_mem [NUM_SETS];
  logic [LINE_WORDS-1:0][WORD_W-1:0] line_q;   // line read last cycle

  always_ff @(posedge i_clk) begin
    if (i_fill.en) begin
      data_mem[i_req.index][i_fill.wsel] <= i_fill.data;  // one word per beat
    end
    line_q <= data_mem[i_rd_index];
  end

  // pick the requested word out of the line
  assign o_word = line_q[i_req.wsel];

endmodule

`default_nettype wire

// File: logic/icache_hit_merge.sv
// Instruction cache hit merge
`timescale 1ns/1ps
`default_nettype none

module icache_hit_merge import icache_pkg::*; (
  input  wire logic [NUM_WAYS-1:0]              i_hit,
  input  wire logic [NUM_WAYS-1:0][WORD_W-1:0]  i_word,
  input  wire logic [WORD_W-1:0]                i_ret_data,
  input  wire logic                             i_refill,
  output logic                                  o_hit,
  output logic [WORD_W-1:0]                     o_rdata
);

  logic [WORD_W-1:0] hit_word;

  assign o_hit = |i_hit;

  // at most one way hits, so and-or is enough
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_word = hit_word | ({WORD_W{i_hit[w]}} & i_word[w]);
    end
  end

  assign o_rdata = i_refill ? i_ret_data : hit_word;  // bus beat during refill

endmodule

`default_nettype wire

// File: logic/icache_top.sv
// Instruction cache top
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic                 i_clk,
  input  wire logic                 i_rst,
  // fetch side
  input  wire logic                 i_valid,
  input  wire logic [TAG_W-1:0]     i_tag,
  input  wire logic [INDEX_W-1:0]   i_index,
  input  wire logic [OFFSET_W-1:0]  i_offset,
  output logic                      o_addr_ok,
  output logic                      o_data_ok,
  output logic [WORD_W-1:0]         o_rdata,
  // bus side
  output logic                      o_rd_req,
  output logic [ADDR_W-1:0]         o_rd_addr,
  input  wire logic                 i_rd_rdy,
  input  wire logic                 i_ret_valid,
  input  wire logic                 i_ret_last,
  input  wire logic [WORD_W-1:0]    i_ret_data
);

  req_t                         req;
  logic [INDEX_W-1:0]           rd_index;
  fill_t [NUM_WAYS-1:0]         fill;
  logic [NUM_WAYS-1:0]          way_hit;
  logic [NUM_WAYS-1:0][WORD_W-1:0] way_word;
  logic                         hit;
  logic                         refill;

  icache_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_tag       (i_tag),
    .i_index     (i_index),
    .i_offset    (i_offset),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .i_hit       (hit),
    .o_refill    (refill),
    .o_req       (req),
    .o_rd_index  (rd_index),
    .o_fill      (fill),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data)
  );

  // ------------------------------
  // ways
  // ------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    icache_way u_way (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_req      (req),
      .i_rd_index (rd_index),
      .i_fill     (fill[w]),
      .o_hit      (way_hit[w]),
      .o_word     (way_word[w])
    );
  end

  icache_hit_merge u_merge (
    .i_hit      (way_hit),
    .i_word     (way_word),
    .i_ret_data (i_ret_data),
    .i_refill   (refill),
    .o_hit      (hit),
    .o_rdata    (o_rdata)
  );

endmodule

`default_nettype wire

// File: verification/icache_properties.sv
// Instruction cache handshake properties
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
  input wire logic i_clk,
  input wire logic i_rst,
  input wire logic i_valid,
  input wire logic o_addr_ok,
  input wire logic o_data_ok,
  input wire logic o_rd_req,
  input wire logic i_rd_rdy,
  input wire logic i_refill
);

  logic [3:0] outstanding;  // accepted and not yet returned

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      outstanding <= '0;
    end else begin
      case ({i_valid && o_addr_ok, o_data_ok})
        2'b10:   outstanding <= outstanding + 4'd1;
        2'b01:   outstanding <= outstanding - 4'd1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // ------------------------------
  a_rd_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rd_req && !i_rd_rdy) |=> o_rd_req)
    else $error("o_rd_req dropped before i_rd_rdy");

  a_no_accept_in_refill: assert property (@(posedge i_clk) disable iff (i_rst)
    i_refill |-> !o_addr_ok)
    else $error("o_addr_ok high during refill");

  a_data_ok_outstanding: assert property (@(posedge i_clk) disable iff (i_rst)
    o_data_ok |-> (outstanding != 4'd0))
    else $error("o_data_ok with no request in flight");

endmodule

bind icache_top icache_properties u_props (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_valid   (i_valid),
  .o_addr_ok (o_addr_ok),
  .o_data_ok (o_data_ok),
  .o_rd_req  (o_rd_req),
  .i_rd_rdy  (i_rd_rdy),
  .i_refill  (refill)
);

`default_nettype wire

// File: verification/icache_checker.sv
// Instruction cache result checker
`timescale 1ns/1ps
`default_nettype none

module icache_checker (
  input  wire logic        i_clk,
  input  wire logic        i_rst,
  input  wire logic [7:0]  i_test_id,
  input  wire logic        i_exp_miss,
  input  wire logic        i_valid,
  input  wire logic [20:0] i_tag,
  input  wire logic [5:0]  i_index,
  input  wire logic [4:0]  i_offset,
  input  wire logic        o_addr_ok,
  input  wire logic        o_data_ok,
  input  wire logic [63:0] o_rdata,
  input  wire logic        o_rd_req,
  input  wire logic [31:0] o_rd_addr,
  input  wire logic        i_rd_rdy,
  output int               o_pending,
  output int               o_tests,
  output int               o_fails,
  output int               o_errors
);

  logic [31:0] addr_q [$];   // accepted requests in order
  bit          miss_q [$];
  int          cyc_q  [$];
  bit          miss_seen;    // head request went to the bus
  int          cyc = 0;
  int          test_err = 0;
  int          test_reqs = 0;
  logic [7:0]  cur_id = 8'd0;

  initial begin
    o_pending = 0;
    o_tests   = 0;
    o_fails   = 0;
    o_errors  = 0;
    miss_seen = 1'b0;
  end

  // ------------------------------
  always @(negedge i_clk) begin
    logic [31:0] a;
    logic [31:0] wa;
    logic [63:0] exp_data;
    if (i_test_id != cur_id) begin
      if (cur_id != 8'd0) begin
        $display("test %0d: %s, %0d requests, %0d errors", cur_id,
                 (test_err == 0) ? "ok" : "failed", test_reqs, test_err);
        o_tests = o_tests + 1;
        if (test_err != 0) o_fails = o_fails + 1;
      end
      cur_id    = i_test_id;
      test_err  = 0;
      test_reqs = 0;
    end
    if (i_rst) begin
      addr_q.delete();
      miss_q.delete();
      cyc_q.delete();
      miss_seen = 1'b0;
    end else begin
      if (o_data_ok) begin               // oldest request returns first
        if (addr_q.size() == 0) begin
          $display("o_data_ok came with no outstanding request");
          test_err++;
          o_errors++;
        end else begin
          a        = addr_q.pop_front();
          wa       = {a[31:3], 3'b000};
          exp_data = {wa, ~wa};          // data rule of the memory
          if (o_rdata !== exp_data) begin
            $display("CHECK FAILED o_rdata addr %h: got %h expected %h", a, o_rdata, exp_data);
            test_err++;
            o_errors++;
          end
          if (miss_seen != miss_q[0]) begin
            $display("CHECK FAILED miss flag addr %h: got %h expected %h",
                     a, miss_seen, miss_q[0]);
            test_err++;
            o_errors++;
          end
          if (!miss_seen && (cyc - cyc_q[0] != 1)) begin
            $display("hit for address %h returned %0d cycles after acceptance",
                     a, cyc - cyc_q[0]);
            test_err++;
            o_errors++;
          end
          if (!miss_seen && i_valid && !o_addr_ok) begin
            $display("held request at %h was not accepted with the hit for %h",
                     {i_tag, i_index, i_offset}, a);
            test_err++;
            o_errors++;
          end
          void'(miss_q.pop_front());
          void'(cyc_q.pop_front());
          miss_seen = 1'b0;
          test_reqs++;
        end
      end
      if (o_rd_req && i_rd_rdy) begin    // one line read per miss
        if (addr_q.size() == 0 || miss_seen) begin
          $display("unexpected read request on the bus at %h", o_rd_addr);
          test_err++;
          o_errors++;
        end else if (o_rd_addr !== {addr_q[0][31:5], 5'b00000}) begin
          $display("CHECK FAILED o_rd_addr: got %h expected %h",
                   o_rd_addr, {addr_q[0][31:5], 5'b00000});
          test_err++;
          o_errors++;
        end
        miss_seen = 1'b1;
      end
      if (i_valid && o_addr_ok) begin
        addr_q.push_back({i_tag, i_index, i_offset});
        miss_q.push_back(i_exp_miss);
        cyc_q.push_back(cyc);
      end
    end
    o_pending = addr_q.size();
    cyc++;
  end

endmodule

`default_nettype wire

// File: verification/icache_tb.sv
// Instruction cache testbench
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  logic        clk = 1'b0;
  logic        i_rst, i_valid;
  logic [20:0] i_tag;
  logic [5:0]  i_index;
  logic [4:0]  i_offset;
  logic        i_rd_rdy, i_ret_valid, i_ret_last;
  logic [63:0] i_ret_data;
  wire         o_addr_ok, o_data_ok, o_rd_req;
  wire  [63:0] o_rdata;
  wire  [31:0] o_rd_addr;
  logic [7:0]  test_id;
  logic        exp_miss;
  logic [47:0] stim [64];
  integer      seed = 32'hb9749af1;
  bit          timed_out = 1'b0;
  int          pending, tests, fails, errors;

  always #4 clk = ~clk;  // 8 ns period

  icache_top UUT (
    .i_clk(clk), .i_rst(i_rst), .i_valid(i_valid), .i_tag(i_tag),
    .i_index(i_index), .i_offset(i_offset), .o_addr_ok(o_addr_ok),
    .o_data_ok(o_data_ok), .o_rdata(o_rdata), .o_rd_req(o_rd_req),
    .o_rd_addr(o_rd_addr), .i_rd_rdy(i_rd_rdy), .i_ret_valid(i_ret_valid),
    .i_ret_last(i_ret_last), .i_ret_data(i_ret_data)
  );

  icache_checker u_checker (
    .i_clk(clk), .i_rst(i_rst), .i_test_id(test_id), .i_exp_miss(exp_miss),
    .i_valid(i_valid), .i_tag(i_tag), .i_index(i_index), .i_offset(i_offset),
    .o_addr_ok(o_addr_ok), .o_data_ok(o_data_ok), .o_rdata(o_rdata),
    .o_rd_req(o_rd_req), .o_rd_addr(o_rd_addr), .i_rd_rdy(i_rd_rdy),
    .o_pending(pending), .o_tests(tests), .o_fails(fails), .o_errors(errors)
  );

  // ------------------------------
  // memory model with random gaps
  always begin
    int          gap;
    logic [31:0] wa;
    @(negedge clk);
    if (o_rd_req && !i_rst) begin
      @(posedge clk);
      gap = $random(seed) & 3;
      repeat (gap) @(posedge clk);
      i_rd_rdy <= 1'b1;
      @(posedge clk);                    // request taken here
      i_rd_rdy <= 1'b0;
      for (int b = 0; b < 4; b++) begin
        gap = $random(seed) & 3;
        if (gap > 0) begin
          i_ret_valid <= 1'b0;
          repeat (gap) @(posedge clk);
        end
        wa = o_rd_addr + 32'(b * 8);
        i_ret_valid <= 1'b1;
        i_ret_data  <= {wa, ~wa};
        i_ret_last  <= (b == 3);
        @(posedge clk);
      end
      i_ret_valid <= 1'b0;
      i_ret_last  <= 1'b0;
    end
  end

  // ------------------------------
  task automatic wait_accept(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < 200; n++) begin
      @(negedge clk);
      if (o_addr_ok) begin
        ok = 1'b1;
        break;
      end
    end
    if (ok) @(posedge clk);              // acceptance edge
    else $display("timeout: request was never accepted");
  endtask

  task automatic drain_pending(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < 200; n++) begin
      @(posedge clk);
      if (pending == 0) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) $display("timeout: data never returned for a request");
  endtask

  initial begin
    logic [47:0] e;
    bit          ok;
    int          i;
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_tag = '0;
    i_index = '0;
    i_offset = '0;
    i_rd_rdy = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last = 1'b0;
    i_ret_data = '0;
    test_id = 8'd0;
    exp_miss = 1'b0;
    for (i = 0; i < 64; i++) stim[i] = '0;
    $readmemh("verification/icache_stim.txt", stim);
    repeat (2) @(posedge clk);
    i_rst <= 1'b0;
    i = 0;
    while (i < 64 && stim[i][39:36] != 4'd0 && !timed_out) begin
      e = stim[i];
      test_id <= e[47:40];
      if (e[39:36] == 4'd2) begin        // reset command
        i_valid <= 1'b0;
        i_rst   <= 1'b1;
        repeat (2) @(posedge clk);
        i_rst   <= 1'b0;
      end else begin
        i_valid  <= 1'b1;
        i_tag    <= e[35:15];
        i_index  <= e[14:9];
        i_offset <= e[8:4];
        exp_miss <= e[0];
        wait_accept(ok);
        if (!ok) begin
          timed_out = 1'b1;
        end else if (e[39:36] == 4'd1) begin
          i_valid <= 1'b0;
          drain_pending(ok);
          if (!ok) timed_out = 1'b1;
        end
      end
      i++;
    end
    test_id <= 8'd0;                     // closes the last test
    repeat (2) @(posedge clk);
    $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
    if (timed_out || errors != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_way.sv
logic/icache_hit_merge.sv
logic/icache_top.sv
verification/icache_properties.sv
verification/icache_checker.sv
verification/icache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module icache_tb -o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"

if grep -q "^RESULT: PASS$" <<< "$out"; then
  exit 0
fi
exit 1

// File: verification/icache_stim.txt
// test id (8) _ command (4: 1 request, 3 request held back to back, 2 reset)
// _ byte address (32) _ expected miss (4)
01_1_00001238_1
02_1_00001220_0
02_1_00001228_0
02_1_00001230_0
02_1_00001238_0
03_3_00001230_0
03_3_00001220_0
03_3_00001238_0
03_1_00001228_0
04_1_000008a0_1
04_1_000010a0_1
04_1_000018a0_1
04_1_000008a0_1
04_1_000018a0_0
04_1_000010a0_1
05_1_00001238_0
05_2_00000000_0
05_1_00001238_1
05_1_00001230_0
